// ==== cpu7_config.svh ====
`ifndef CPU7_CONFIG_SVH
`define CPU7_CONFIG_SVH

//==========================================================================
// core front end configuration
//==========================================================================

// register and pc width
`define CPU7_GRLEN 32

// shared instruction and data memory in 32-bit words
`define CPU7_MEM_WORDS 256
// word address width into that memory
`define CPU7_MEM_AW 8

// byte step between two sequential instructions
`define CPU7_INST_BYTES 4

`endif

// ==== cpu7_pkg.sv ====
`default_nettype none
`include "cpu7_config.svh"

package cpu7_pkg;

   // one access from a client to the shared memory
   typedef struct packed {
      logic                    we;
      logic [`CPU7_MEM_AW-1:0] addr;
      logic [31:0]             wdata;
   } mem_req_t;

   // response back to a client
   // data is don't care for writes
   typedef struct packed {
      logic        valid;
      logic [31:0] rdata;
   } mem_rsp_t;

   // fetch redirects from the back end
   typedef struct packed {
      logic                   br_taken;
      logic [`CPU7_GRLEN-1:0] br_target;
      logic                   except;
      logic [`CPU7_GRLEN-1:0] eentry;
      logic                   ertn;
      logic [`CPU7_GRLEN-1:0] era;
   } redirect_t;

   // handoff to decode with the kill already applied
   typedef struct packed {
      logic                   valid;
      logic [`CPU7_GRLEN-1:0] pc;
      logic [31:0]            inst;
   } dec_out_t;

   // command on the external debug port
   typedef struct packed {
      logic                    we;
      logic [`CPU7_MEM_AW-1:0] addr;
      logic [31:0]             wdata;
   } dbg_cmd_t;

endpackage

`default_nettype wire

// ==== cpu7_sram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu7_config.svh"

module cpu7_sram (
   input  logic               clk,
   input  logic               en,
   input  cpu7_pkg::mem_req_t req,
   output logic [31:0]        rdata
);

   //==========================================================================
   // word array
   //==========================================================================

   // no reset on the contents
   // the testbench loads them over the debug port
   logic [31:0] mem [`CPU7_MEM_WORDS];

   // write only on a granted strobe
   always_ff @(posedge clk) begin
      if (en && req.we) begin
         mem[req.addr] <= req.wdata;
      end
   end

   // read port
   // address register in the arbiter stays put after the strobe
   // so the word is ready one cycle after en
   // a write returns the old word which the client ignores
   always_ff @(posedge clk) begin
      rdata <= mem[req.addr];
   end

endmodule

`default_nettype wire

// ==== cpu7_mem_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu7_mem_arb (
   input  logic               clk,
   input  logic               rst,
   // fetch client
   input  logic               f_req,
   input  cpu7_pkg::mem_req_t f_cmd,
   output cpu7_pkg::mem_rsp_t f_rsp,
   // debug client
   input  logic               d_req,
   input  cpu7_pkg::mem_req_t d_cmd,
   output cpu7_pkg::mem_rsp_t d_rsp,
   // memory side
   output logic               m_en,
   output cpu7_pkg::mem_req_t m_req,
   input  logic [31:0]        m_rdata
);

   // one-hot owner of the access in flight
   // bit 0 fetch, bit 1 debug
   logic [1:0] owner;
   logic       busy;
   // set when debug got the last grant
   logic       last_d;
   // memory word shows up in this cycle
   logic       rsp_pend;
   logic       grant_ok;
   logic       gnt_f;
   logic       gnt_d;

   //==========================================================================
   // grant
   //==========================================================================

   assign busy = |owner;

   // free again in the cycle the owner gets its response
   // the owner drops req in that cycle so only the peer can win
   assign grant_ok = ~busy | rsp_pend;

   // round robin on a tie
   assign gnt_f = grant_ok & f_req & (~d_req | last_d);
   assign gnt_d = grant_ok & d_req & (~f_req | ~last_d);

   always_ff @(posedge clk) begin
      if (rst) begin
         owner    <= 2'b00;
         last_d   <= 1'b0;
         m_en     <= 1'b0;
         rsp_pend <= 1'b0;
      end else begin
         // one-cycle strobe per grant
         m_en     <= gnt_f | gnt_d;
         // sram answers one cycle after the strobe
         rsp_pend <= m_en;
         if (gnt_f || gnt_d) begin
            owner  <= {gnt_d, gnt_f};
            last_d <= gnt_d;
         end else if (rsp_pend) begin
            owner <= 2'b00;
         end
      end
   end

   // command held stable until the next grant
   always_ff @(posedge clk) begin
      if (gnt_f) begin
         m_req <= f_cmd;
      end else if (gnt_d) begin
         m_req <= d_cmd;
      end
   end

   //==========================================================================
   // response steering
   //==========================================================================

   // valid to the recorded owner only
   always_comb begin
      f_rsp.valid = rsp_pend & owner[0];
      f_rsp.rdata = m_rdata;
      d_rsp.valid = rsp_pend & owner[1];
      d_rsp.rdata = m_rdata;
   end

endmodule

`default_nettype wire

// ==== cpu7_dbg_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu7_dbg_port (
   input  logic               clk,
   input  logic               rst,
   input  logic               dbg_req,
   input  cpu7_pkg::dbg_cmd_t dbg_cmd,
   output logic               dbg_ack,
   output logic [31:0]        dbg_rdata,
   output logic               m_req,
   output cpu7_pkg::mem_req_t m_cmd,
   input  cpu7_pkg::mem_rsp_t m_rsp
);

   typedef enum logic [1:0] {
      S_IDLE   = 2'd0,
      S_ACCESS = 2'd1,
      S_ACKED  = 2'd2
   } state_t;

   state_t             state;
   cpu7_pkg::dbg_cmd_t cmd_q;
   logic [31:0]        rdata_q;

   // four-phase handshake outside
   // level request to the arbiter inside
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE:   if (dbg_req) state <= S_ACCESS;
            S_ACCESS: if (m_rsp.valid) state <= S_ACKED;
            // wait for the host to let go
            S_ACKED:  if (!dbg_req) state <= S_IDLE;
            default:  state <= S_IDLE;
         endcase
      end
   end

   // command taken once per handshake
   always_ff @(posedge clk) begin
      if (state == S_IDLE && dbg_req) begin
         cmd_q <= dbg_cmd;
      end
      // read word kept for the whole ack phase
      if (state == S_ACCESS && m_rsp.valid && !cmd_q.we) begin
         rdata_q <= m_rsp.rdata;
      end
   end

   // drop in the response cycle so only one access goes out
   assign m_req = (state == S_ACCESS) & ~m_rsp.valid;

   always_comb begin
      m_cmd.we    = cmd_q.we;
      m_cmd.addr  = cmd_q.addr;
      m_cmd.wdata = cmd_q.wdata;
   end

   assign dbg_ack   = (state == S_ACKED);
   assign dbg_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== cpu7_ifu_fdp.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu7_config.svh"

module cpu7_ifu_fdp (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`CPU7_GRLEN-1:0] pc_init,
   input  cpu7_pkg::redirect_t    redir,
   input  logic                   stall_req,
   output logic                   m_req,
   output cpu7_pkg::mem_req_t     m_cmd,
   input  cpu7_pkg::mem_rsp_t     m_rsp,
   output cpu7_pkg::dec_out_t     dec,
   output logic                   valid_e,
   output logic [`CPU7_GRLEN-1:0] pc_e,
   output logic [`CPU7_GRLEN-1:0] pc_w
);

   localparam int unsigned INST_SHIFT = $clog2(`CPU7_INST_BYTES);

   logic                   redir_any;
   logic                   kill_d;
   logic [`CPU7_GRLEN-1:0] pc_bf;
   logic [`CPU7_GRLEN-1:0] pc_f;
   logic [`CPU7_GRLEN-1:0] pcinc_f;
   logic [`CPU7_GRLEN-1:0] pc_d;
   logic [`CPU7_GRLEN-1:0] pc_m;
   logic [31:0]            inst_d;
   logic [31:0]            inst_f;
   logic [`CPU7_MEM_AW-1:0] fch_addr;
   logic                   run;
   logic                   adv;
   logic                   stale;
   logic                   req_q;
   logic                   req_bgn;
   logic                   req_in;
   logic                   issue;
   logic                   rsp_vld_f;
   logic                   kill_vld_f;
   logic                   hold_v;
   logic [31:0]            hold_inst;
   logic                   valid_d;
   logic                   kill_vld_d;
   logic                   pc_f2d_en;
   logic                   pc_d2e_en;

   // ertn kills only the fetch side
   assign redir_any = redir.br_taken | redir.except | redir.ertn;
   assign kill_d    = redir.br_taken | redir.except;

   //==========================================================================
   // pc datapath
   //==========================================================================

   assign pcinc_f = pc_f + `CPU7_GRLEN'(`CPU7_INST_BYTES);

   // next fetch pc by priority
   // adv marks pc_f as delivered so the step is taken
   always_comb begin
      if (redir.except) begin
         pc_bf = redir.eentry;
      end else if (redir.ertn) begin
         pc_bf = redir.era;
      end else if (redir.br_taken) begin
         pc_bf = redir.br_target;
      end else if (adv) begin
         pc_bf = pcinc_f;
      end else begin
         pc_bf = pc_f;
      end
   end

   // pc_f tracks the issued fetch
   // a redirect overwrites it since that fetch goes stale
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_f <= pc_init;
      end else if (redir_any || issue) begin
         pc_f <= pc_bf;
      end
   end

   //==========================================================================
   // memory request
   //==========================================================================

   // level request held until the response valid
   assign req_bgn = run & ~stall_req;
   assign req_in  = (req_q | req_bgn) & ~m_rsp.valid;
   assign issue   = req_in & ~req_q;
   assign m_req   = req_in;

   // address from pc_bf on the first cycle then from the latch
   always_comb begin
      m_cmd.we    = 1'b0;
      m_cmd.addr  = req_q ? fch_addr : pc_bf[INST_SHIFT +: `CPU7_MEM_AW];
      m_cmd.wdata = '0;
   end

   //==========================================================================
   // fetch to decode to execute
   //==========================================================================

   // stale data never reaches decode
   assign rsp_vld_f  = m_rsp.valid & ~stale;
   // held word goes first once the stall ends
   assign inst_f     = hold_v ? hold_inst : m_rsp.rdata;
   assign kill_vld_f = (hold_v | rsp_vld_f) & ~redir_any;
   assign kill_vld_d = valid_d & ~kill_d;

   assign pc_f2d_en = kill_vld_f & ~stall_req;
   assign pc_d2e_en = kill_vld_d & ~stall_req;

   always_ff @(posedge clk) begin
      if (rst) begin
         run     <= 1'b0;
         req_q   <= 1'b0;
         stale   <= 1'b0;
         adv     <= 1'b0;
         hold_v  <= 1'b0;
         valid_d <= 1'b0;
         valid_e <= 1'b0;
      end else begin
         run   <= 1'b1;
         req_q <= req_in;
         // redirect while a fetch is out
         if (m_rsp.valid) begin
            stale <= 1'b0;
         end else if (redir_any && req_q) begin
            stale <= 1'b1;
         end
         if (redir_any || issue) begin
            adv <= 1'b0;
         end else if (rsp_vld_f) begin
            adv <= 1'b1;
         end
         // one-entry hold for a word that lands under stall
         if (redir_any || !stall_req) begin
            hold_v <= 1'b0;
         end else if (rsp_vld_f) begin
            hold_v <= 1'b1;
         end
         // a kill clears decode even under stall
         if (!stall_req || kill_d) begin
            valid_d <= kill_vld_f;
         end
         if (!stall_req) begin
            valid_e <= kill_vld_d;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         fch_addr <= pc_bf[INST_SHIFT +: `CPU7_MEM_AW];
      end
      if (stall_req && rsp_vld_f) begin
         hold_inst <= m_rsp.rdata;
      end
      if (pc_f2d_en) begin
         pc_d   <= pc_f;
         inst_d <= inst_f;
      end
      if (pc_d2e_en) begin
         pc_e <= pc_d;
      end
      // debug copies down the pipe
      pc_m <= pc_e;
      pc_w <= pc_m;
   end

   always_comb begin
      dec.valid = kill_vld_d;
      dec.pc    = pc_d;
      dec.inst  = inst_d;
   end

endmodule

`default_nettype wire

// ==== cpu7_ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu7_config.svh"

module cpu7_ifu_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`CPU7_GRLEN-1:0] pc_init,
   input  cpu7_pkg::redirect_t    redir,
   input  logic                   stall_req,
   output cpu7_pkg::dec_out_t     dec,
   output logic                   valid_e,
   output logic [`CPU7_GRLEN-1:0] pc_e,
   output logic [`CPU7_GRLEN-1:0] pc_w,
   input  logic                   dbg_req,
   input  cpu7_pkg::dbg_cmd_t     dbg_cmd,
   output logic                   dbg_ack,
   output logic [31:0]            dbg_rdata
);

   // fetch client
   logic               f_req;
   cpu7_pkg::mem_req_t f_cmd;
   cpu7_pkg::mem_rsp_t f_rsp;
   // debug client
   logic               d_req;
   cpu7_pkg::mem_req_t d_cmd;
   cpu7_pkg::mem_rsp_t d_rsp;
   // arbiter to sram
   logic               mem_en;
   cpu7_pkg::mem_req_t mem_cmd;
   logic [31:0]        mem_rdata;

   cpu7_ifu_fdp u_fdp (
      .clk(clk), .rst(rst), .pc_init(pc_init), .redir(redir),
      .stall_req(stall_req), .m_req(f_req), .m_cmd(f_cmd), .m_rsp(f_rsp),
      .dec(dec), .valid_e(valid_e), .pc_e(pc_e), .pc_w(pc_w)
   );

   cpu7_dbg_port u_dbg (
      .clk(clk), .rst(rst), .dbg_req(dbg_req), .dbg_cmd(dbg_cmd),
      .dbg_ack(dbg_ack), .dbg_rdata(dbg_rdata),
      .m_req(d_req), .m_cmd(d_cmd), .m_rsp(d_rsp)
   );

   cpu7_mem_arb u_arb (
      .clk(clk), .rst(rst),
      .f_req(f_req), .f_cmd(f_cmd), .f_rsp(f_rsp),
      .d_req(d_req), .d_cmd(d_cmd), .d_rsp(d_rsp),
      .m_en(mem_en), .m_req(mem_cmd), .m_rdata(mem_rdata)
   );

   cpu7_sram u_sram (
      .clk(clk), .en(mem_en), .req(mem_cmd), .rdata(mem_rdata)
   );

endmodule

`default_nettype wire

// ==== tb_cpu7_ifu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu7_config.svh"

module tb_cpu7_ifu;

   localparam int unsigned WAIT_LIMIT = 400;
   localparam int unsigned SH = $clog2(`CPU7_INST_BYTES);
   localparam logic [`CPU7_GRLEN-1:0] PC_START = 32'h40;

   logic                   clk = 1'b0;
   logic                   rst;
   logic [`CPU7_GRLEN-1:0] pc_init;
   cpu7_pkg::redirect_t    redir;
   logic                   stall_req;
   cpu7_pkg::dec_out_t     dec;
   logic                   valid_e;
   logic [`CPU7_GRLEN-1:0] pc_e;
   logic [`CPU7_GRLEN-1:0] pc_w;
   logic                   dbg_req;
   cpu7_pkg::dbg_cmd_t     dbg_cmd;
   logic                   dbg_ack;
   logic [31:0]            dbg_rdata;

   // reference copy of the shared memory
   logic [31:0]            mirror [`CPU7_MEM_WORDS];
   // reference pc model
   logic [`CPU7_GRLEN-1:0] exp_pc;
   logic [`CPU7_GRLEN-1:0] last_dec_pc;
   // expected execute pc
   logic [`CPU7_GRLEN-1:0] exp_e;
   logic [`CPU7_GRLEN-1:0] pe_q1;
   logic [`CPU7_GRLEN-1:0] pe_q2;
   logic                   was_event;
   int unsigned            n_events;
   // cycles since valid_e first seen, saturating
   logic [1:0]             e_age;
   int unsigned            err_mon = 0;
   int unsigned            err_prop = 0;
   int unsigned            err_seq = 0;
   int unsigned            timeouts = 0;

   cpu7_ifu_top dut (
      .clk(clk), .rst(rst), .pc_init(pc_init), .redir(redir),
      .stall_req(stall_req), .dec(dec), .valid_e(valid_e), .pc_e(pc_e),
      .pc_w(pc_w), .dbg_req(dbg_req), .dbg_cmd(dbg_cmd), .dbg_ack(dbg_ack),
      .dbg_rdata(dbg_rdata)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [`CPU7_MEM_AW-1:0] word_of(input logic [`CPU7_GRLEN-1:0] pc);
      return pc[SH +: `CPU7_MEM_AW];
   endfunction

   //==========================================================================
   // stimulus tasks
   //==========================================================================

   // one four-phase access on the debug port
   task automatic dbg_access(input logic we, input logic [`CPU7_MEM_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int unsigned n;
      @(posedge clk);
      dbg_cmd <= '{we: we, addr: addr, wdata: wdata};
      dbg_req <= 1'b1;
      n = 0;
      @(posedge clk);
      while (!dbg_ack && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (!dbg_ack) begin
         timeouts++;
         $display("timeout: debug ack never rose for address %h", addr);
      end
      rdata = dbg_rdata;
      dbg_req <= 1'b0;
      n = 0;
      @(posedge clk);
      while (dbg_ack && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (dbg_ack) begin
         timeouts++;
         $display("timeout: debug ack stuck high after req fell");
      end
   endtask

   // wait for a number of decode handoffs
   task automatic wait_events(input int unsigned count);
      int unsigned target;
      int unsigned n;
      target = n_events + count;
      n = 0;
      @(posedge clk);
      while (n_events < target && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (n_events < target) begin
         timeouts++;
         $display("timeout: decode stream stopped after %0d handoffs", n_events);
      end
   endtask

   task automatic pulse_redirect(input logic br, input logic [`CPU7_GRLEN-1:0] tgt,
                                 input logic ex, input logic [`CPU7_GRLEN-1:0] ent,
                                 input logic er, input logic [`CPU7_GRLEN-1:0] ra);
      cpu7_pkg::redirect_t r;
      r = '0;
      r.br_taken  = br;
      r.br_target = tgt;
      r.except    = ex;
      r.eentry    = ent;
      r.ertn      = er;
      r.era       = ra;
      @(posedge clk);
      redir <= r;
      @(posedge clk);
      redir <= '0;
   endtask

   task automatic stall_for(input int unsigned cycles);
      @(posedge clk);
      stall_req <= 1'b1;
      repeat (cycles) @(posedge clk);
      stall_req <= 1'b0;
   endtask

   //==========================================================================
   // reference model and checks
   //==========================================================================

   always @(posedge clk) begin
      if (rst) begin
         e_age <= 2'd0;
      end else if (e_age != 2'd0 || valid_e) begin
         e_age <= (e_age == 2'd3) ? 2'd3 : e_age + 2'd1;
      end
   end

   always @(posedge clk) begin
      if (rst) begin
         exp_pc = PC_START;
         was_event = 1'b0;
         n_events <= 0;
      end else begin
         // execute takes the pc handed off one cycle earlier
         if (was_event) begin
            exp_e = last_dec_pc;
            assert (valid_e) else begin
               err_mon = err_mon + 1;
               $display("valid_e did not follow a decode handoff");
            end
            assert (pc_e === exp_e) else begin
               err_mon = err_mon + 1;
               $display("Mismatch pc_e: got %h expected %h", pc_e, exp_e);
            end
         end
         // writeback copy trails execute by two cycles
         if (e_age >= 2'd2) begin
            assert (pc_w === pe_q2) else begin
               err_mon = err_mon + 1;
               $display("Mismatch pc_w: got %h expected %h", pc_w, pe_q2);
            end
         end
         pe_q2 = pe_q1;
         pe_q1 = exp_e;
         was_event = dec.valid && !stall_req;
         if (was_event) begin
            assert (dec.pc === exp_pc) else begin
               err_mon = err_mon + 1;
               $display("Mismatch dec.pc: got %h expected %h", dec.pc, exp_pc);
            end
            assert (dec.inst === mirror[word_of(exp_pc)]) else begin
               err_mon = err_mon + 1;
               $display("Mismatch dec.inst: got %h expected %h at pc %h",
                        dec.inst, mirror[word_of(exp_pc)], exp_pc);
            end
            last_dec_pc = exp_pc;
            exp_pc = exp_pc + `CPU7_GRLEN'(`CPU7_INST_BYTES);
            n_events <= n_events + 1;
         end
         // exception entry beats era beats branch
         if (redir.except) begin
            exp_pc = redir.eentry;
         end else if (redir.ertn) begin
            exp_pc = redir.era;
         end else if (redir.br_taken) begin
            exp_pc = redir.br_target;
         end
      end
   end

   // decode and execute hold under stall
   assert property (@(posedge clk) disable iff (rst)
      (stall_req && e_age >= 2'd2) |=> ($stable(dec) && $stable(pc_e)))
   else begin
      err_prop = err_prop + 1;
      $display("decode or execute state changed during a stall");
   end

   // debug handshake order
   assert property (@(posedge clk) disable iff (rst) $rose(dbg_ack) |-> dbg_req)
   else begin
      err_prop = err_prop + 1;
      $display("debug ack rose without a request");
   end

   assert property (@(posedge clk) disable iff (rst) $fell(dbg_ack) |-> $past(!dbg_req))
   else begin
      err_prop = err_prop + 1;
      $display("debug ack fell while the request was still high");
   end

   assert property (@(posedge clk) disable iff (rst) (dbg_ack && dbg_req) |=> dbg_ack)
   else begin
      err_prop = err_prop + 1;
      $display("debug ack dropped before the request fell");
   end

   //==========================================================================
   // test sequence
   //==========================================================================

   initial begin
      logic [31:0]             seed;
      logic [31:0]             rd;
      logic [31:0]             wd;
      logic [`CPU7_MEM_AW-1:0] wa;
      rst       <= 1'b1;
      pc_init   <= PC_START;
      redir     <= '0;
      stall_req <= 1'b1;
      dbg_req   <= 1'b0;
      dbg_cmd   <= '0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      // program load with fetch held off
      seed = 32'hba07;
      for (int w = 0; w < `CPU7_MEM_WORDS; w++) begin
         seed = lcg_next(seed);
         wa = w[`CPU7_MEM_AW-1:0];
         mirror[wa] = seed;
         dbg_access(1'b1, wa, seed, rd);
      end

      // sequential fetch from pc_init
      @(posedge clk);
      stall_req <= 1'b0;
      wait_events(20);

      // branch, then exception, return and the two tie cases
      pulse_redirect(1'b1, 32'h100, 1'b0, '0, 1'b0, '0);
      wait_events(8);
      pulse_redirect(1'b0, '0, 1'b1, 32'h20, 1'b0, '0);
      wait_events(6);
      pulse_redirect(1'b0, '0, 1'b0, '0, 1'b1, 32'h80);
      wait_events(6);
      pulse_redirect(1'b0, '0, 1'b1, 32'h10, 1'b1, 32'h3c0);
      wait_events(6);
      pulse_redirect(1'b1, 32'h200, 1'b1, 32'h30, 1'b0, '0);
      wait_events(6);

      // stalls that start at different fetch phases
      for (int i = 0; i < 4; i++) begin
         wait_events(3);
         repeat (i) @(posedge clk);
         stall_for(4 + i);
      end
      wait_events(4);

      // debug traffic in the upper half while fetch runs low
      pulse_redirect(1'b1, 32'h0, 1'b0, '0, 1'b0, '0);
      for (int i = 0; i < 6; i++) begin
         seed = lcg_next(seed);
         wa = {1'b1, seed[`CPU7_MEM_AW-2:0]};
         wd = lcg_next(seed);
         seed = wd;
         dbg_access(1'b1, wa, wd, rd);
         mirror[wa] = wd;
         dbg_access(1'b0, wa, '0, rd);
         assert (rd === wd) else begin
            err_seq = err_seq + 1;
            $display("Mismatch dbg_rdata: got %h expected %h at word %h", rd, wd, wa);
         end
      end
      wait_events(4);

      $display("errors: monitor %0d, property %0d, sequence %0d, timeouts %0d",
               err_mon, err_prop, err_seq, timeouts);
      if (err_mon + err_prop + err_seq + timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
cpu7_pkg.sv
cpu7_sram.sv
cpu7_mem_arb.sv
cpu7_dbg_port.sv
cpu7_ifu_fdp.sv
cpu7_ifu_top.sv
tb_cpu7_ifu.sv

// ==== Makefile ====
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_cpu7_ifu
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
